/* mycpu_top.f */
+incdir+src
src/cpu_pkg.sv
src/decoder.sv
src/reg_file.sv
src/alu.sv
src/hazard_unit.sv
src/fetch_unit.sv
src/execute_stage.sv
src/mycpu_top.sv
verif/tb_mycpu_top.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_mycpu_top -f mycpu_top.f -o tb_mycpu_top

./obj_dir/tb_mycpu_top | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

/* src/alu.sv */
`include "cpu_config.svh"

module alu import cpu_pkg::*; (
    input  alu_op_e              op,
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    output logic [`CPU_XLEN-1:0] y,
    output logic                 zero
);

    logic [4:0] sa;

    assign sa = a[4:0];     // shift count

    always_comb begin
        case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_AND:  y = a & b;
            ALU_OR:   y = a | b;
            ALU_XOR:  y = a ^ b;
            ALU_NOR:  y = ~(a | b);
            ALU_SLT:  y = {{(`CPU_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: y = {{(`CPU_XLEN-1){1'b0}}, a < b};
            ALU_SLL:  y = b << sa;
            ALU_SRL:  y = b >> sa;
            ALU_SRA:  y = $unsigned($signed(b) >>> sa);
            ALU_LUI:  y = {b[15:0], 16'h0000};
            default:  y = '0;
        endcase
    end

    assign zero = (y == '0);    // beq/bne with ALU_SUB

endmodule

/* src/cpu_config.svh */
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// datapath and register file geometry
`define CPU_XLEN           32
`define CPU_REG_COUNT      32
`define CPU_REG_AW         5

// first fetch after reset, kseg1 boot rom
`define CPU_RESET_PC       32'hbfc0_0000

// upper address bits dropped on the data port
`define CPU_PHYS_MASK_BITS 3

`endif

/* src/cpu_pkg.sv */
package cpu_pkg;

    // primary opcodes, instr[31:26]
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTI    = 6'h0a,
        OP_SLTIU   = 6'h0b,
        OP_ANDI    = 6'h0c,
        OP_ORI     = 6'h0d,
        OP_XORI    = 6'h0e,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    // operand source in EX
    typedef enum logic [1:0] {
        FWD_RF,     // value read in ID
        FWD_MEM,    // EX/MEM result
        FWD_WB      // MEM/WB write data
    } fwd_sel_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    use_imm;
        logic    imm_zero_ext;
        logic    use_shamt;     // a operand is instr shamt
        logic    reg_write;
        logic    dest_rt;       // i-type writes rt
        logic    mem_read;
        logic    mem_write;
        logic    is_branch;
        logic    branch_ne;
        logic    is_jump;
        logic    link;          // jal, r31 <= pc + 8
    } ctrl_t;

endpackage

/* src/decoder.sv */
`include "cpu_config.svh"

module decoder import cpu_pkg::*; (
    input  logic [`CPU_XLEN-1:0]   instr,
    output ctrl_t                  ctrl,
    output logic [`CPU_REG_AW-1:0] rs,
    output logic [`CPU_REG_AW-1:0] rt,
    output logic [`CPU_REG_AW-1:0] rd,
    output logic [15:0]            imm,
    output logic [4:0]             shamt,
    output logic [25:0]            jump_index
);

    opcode_e    opcode;
    logic [5:0] funct;
    logic       funct_ok;

    assign opcode     = opcode_e'(instr[31:26]);
    assign rs         = instr[25:21];
    assign rt         = instr[20:16];
    assign rd         = instr[15:11];
    assign shamt      = instr[10:6];
    assign funct      = instr[5:0];
    assign imm        = instr[15:0];
    assign jump_index = instr[25:0];

    always_comb begin
        ctrl     = '0;
        funct_ok = 1'b0;
        case (opcode)
            OP_SPECIAL: begin
                funct_ok = 1'b1;
                case (funct)
                    6'h00:   ctrl.alu_op = ALU_SLL;
                    6'h02:   ctrl.alu_op = ALU_SRL;
                    6'h03:   ctrl.alu_op = ALU_SRA;
                    6'h21:   ctrl.alu_op = ALU_ADD;     // addu
                    6'h23:   ctrl.alu_op = ALU_SUB;     // subu
                    6'h24:   ctrl.alu_op = ALU_AND;
                    6'h25:   ctrl.alu_op = ALU_OR;
                    6'h26:   ctrl.alu_op = ALU_XOR;
                    6'h27:   ctrl.alu_op = ALU_NOR;
                    6'h2a:   ctrl.alu_op = ALU_SLT;
                    6'h2b:   ctrl.alu_op = ALU_SLTU;
                    default: funct_ok = 1'b0;
                endcase
                ctrl.use_shamt = funct inside {6'h00, 6'h02, 6'h03};
            end
            OP_SLTI:        ctrl.alu_op = ALU_SLT;
            OP_SLTIU:       ctrl.alu_op = ALU_SLTU;
            OP_ANDI:        ctrl.alu_op = ALU_AND;
            OP_ORI:         ctrl.alu_op = ALU_OR;
            OP_XORI:        ctrl.alu_op = ALU_XOR;
            OP_LUI:         ctrl.alu_op = ALU_LUI;
            OP_BEQ, OP_BNE: ctrl.alu_op = ALU_SUB;  // zero flag gives the compare
            default:        ctrl.alu_op = ALU_ADD;  // addiu, lw, sw address
        endcase

        ctrl.use_imm = opcode inside {OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
                                      OP_XORI, OP_LUI, OP_LW, OP_SW};
        ctrl.imm_zero_ext = opcode inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
        ctrl.dest_rt   = ctrl.use_imm && (opcode != OP_SW);
        ctrl.mem_read  = (opcode == OP_LW);
        ctrl.mem_write = (opcode == OP_SW);
        ctrl.is_branch = opcode inside {OP_BEQ, OP_BNE};
        ctrl.branch_ne = (opcode == OP_BNE);
        ctrl.is_jump   = opcode inside {OP_J, OP_JAL};
        ctrl.link      = (opcode == OP_JAL);

        // anything not listed above keeps every enable low and retires as a nop
        ctrl.reg_write = (opcode == OP_SPECIAL) ? funct_ok : (ctrl.dest_rt | ctrl.link);
    end

endmodule

/* src/execute_stage.sv */
`include "cpu_config.svh"

module execute_stage import cpu_pkg::*; (
    input  ctrl_t                ctrl,
    input  logic [`CPU_XLEN-1:0] pc,
    input  logic [`CPU_XLEN-1:0] rs_val,
    input  logic [`CPU_XLEN-1:0] rt_val,
    input  logic [15:0]          imm,
    input  logic [4:0]           shamt,
    input  logic [25:0]          jump_index,
    input  fwd_sel_e             fwd_a,
    input  fwd_sel_e             fwd_b,
    input  logic [`CPU_XLEN-1:0] mem_result,
    input  logic [`CPU_XLEN-1:0] wb_result,
    output logic [`CPU_XLEN-1:0] result,
    output logic [`CPU_XLEN-1:0] store_data,
    output logic                 redirect,
    output logic [`CPU_XLEN-1:0] target
);

    logic [`CPU_XLEN-1:0] op_rs, op_rt;
    logic [`CPU_XLEN-1:0] imm_ext;
    logic [`CPU_XLEN-1:0] alu_a, alu_b, alu_y;
    logic [`CPU_XLEN-1:0] pc_plus4;
    logic                 alu_zero;

    function automatic logic [`CPU_XLEN-1:0] fwd_mux(
        input fwd_sel_e             sel,
        input logic [`CPU_XLEN-1:0] rf_val,
        input logic [`CPU_XLEN-1:0] mem_val,
        input logic [`CPU_XLEN-1:0] wb_val
    );
        case (sel)
            FWD_MEM: return mem_val;
            FWD_WB:  return wb_val;
            default: return rf_val;
        endcase
    endfunction

    assign op_rs = fwd_mux(fwd_a, rs_val, mem_result, wb_result);
    assign op_rt = fwd_mux(fwd_b, rt_val, mem_result, wb_result);

    assign imm_ext = ctrl.imm_zero_ext ? {{(`CPU_XLEN-16){1'b0}}, imm}
                                       : {{(`CPU_XLEN-16){imm[15]}}, imm};

    assign alu_a = ctrl.use_shamt ? {{(`CPU_XLEN-5){1'b0}}, shamt} : op_rs;
    assign alu_b = ctrl.use_imm ? imm_ext : op_rt;

    alu alu_inst (
        .op   (ctrl.alu_op),
        .a    (alu_a),
        .b    (alu_b),
        .y    (alu_y),
        .zero (alu_zero)
    );

    ////////////////////
    // control flow

    assign pc_plus4 = pc + `CPU_XLEN'd4;
    assign redirect = ctrl.is_jump | (ctrl.is_branch & (alu_zero ^ ctrl.branch_ne));
    assign target   = ctrl.is_jump ? {pc_plus4[31:28], jump_index, 2'b00}
                                   : pc_plus4 + {imm_ext[`CPU_XLEN-3:0], 2'b00};

    assign result     = ctrl.link ? pc + `CPU_XLEN'd8 : alu_y;  // jal return address
    assign store_data = op_rt;

endmodule

/* src/fetch_unit.sv */
`include "cpu_config.svh"

module fetch_unit (
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 stall,
    input  logic                 redirect,
    input  logic [`CPU_XLEN-1:0] target,
    input  logic [`CPU_XLEN-1:0] inst_rdata,
    output logic [`CPU_XLEN-1:0] pc,
    output logic [`CPU_XLEN-1:0] id_instr,
    output logic [`CPU_XLEN-1:0] id_pc
);

    logic                 held;         // last cycle was a stall
    logic [`CPU_XLEN-1:0] hold_word;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pc   <= `CPU_RESET_PC;
            held <= 1'b0;
        end else begin
            held <= stall;
            if (redirect)
                pc <= target;
            else if (!stall)
                pc <= pc + `CPU_XLEN'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (stall)
            hold_word <= id_instr;  // sram moves on to pc+4 under the held address
        else
            id_pc <= pc;
    end

    assign id_instr = held ? hold_word : inst_rdata;

    // branch and jump targets from EX keep the pc aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (!resetn) pc[1:0] == 2'b00)
        else $error("fetch pc not word aligned: %h", pc);

endmodule

/* src/hazard_unit.sv */
`include "cpu_config.svh"

module hazard_unit import cpu_pkg::*; (
    input  logic                   clk,
    input  logic [`CPU_REG_AW-1:0] id_rs,
    input  logic [`CPU_REG_AW-1:0] id_rt,
    input  logic [`CPU_REG_AW-1:0] ex_rs,
    input  logic [`CPU_REG_AW-1:0] ex_rt,
    input  logic                   ex_valid,
    input  logic                   ex_mem_read,
    input  logic                   mem_valid,
    input  logic                   mem_reg_write,
    input  logic [`CPU_REG_AW-1:0] mem_rd,
    input  logic                   wb_valid,
    input  logic                   wb_reg_write,
    input  logic [`CPU_REG_AW-1:0] wb_rd,
    input  logic                   redirect,
    input  logic [`CPU_REG_AW-1:0] ex_rd,
    output fwd_sel_e               fwd_a,
    output fwd_sel_e               fwd_b,
    output logic                   stall,
    output logic                   flush
);

    // younger producer wins, r0 never forwards
    function automatic fwd_sel_e pick_src(input logic [`CPU_REG_AW-1:0] src);
        fwd_sel_e sel;
        if (src == '0)
            sel = FWD_RF;
        else if (mem_valid && mem_reg_write && mem_rd == src)
            sel = FWD_MEM;
        else if (wb_valid && wb_reg_write && wb_rd == src)
            sel = FWD_WB;
        else
            sel = FWD_RF;
        return sel;
    endfunction

    always_comb begin
        fwd_a = pick_src(ex_rs);
        fwd_b = pick_src(ex_rt);
    end

    // load in EX feeding ID
    assign stall = ex_valid && ex_mem_read && (ex_rd != '0)
                && (ex_rd == id_rs || ex_rd == id_rt);
    assign flush = redirect;

    // the bubble that follows a stall cannot be a load
    a_single_stall: assert property (@(posedge clk) stall |=> !stall)
        else $error("load-use stall held for two cycles");

endmodule

/* src/mycpu_top.sv */
`include "cpu_config.svh"

module mycpu_top import cpu_pkg::*; (
    input  logic        clk,
    input  logic        resetn,

    output logic        inst_sram_en,
    output logic [3:0]  inst_sram_wen,
    output logic [31:0] inst_sram_addr,
    output logic [31:0] inst_sram_wdata,
    input  logic [31:0] inst_sram_rdata,

    output logic        data_sram_en,
    output logic [3:0]  data_sram_wen,
    output logic [31:0] data_sram_addr,
    output logic [31:0] data_sram_wdata,
    input  logic [31:0] data_sram_rdata,

    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_wen,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    // IF / ID
    logic [`CPU_XLEN-1:0]   if_pc, id_instr, id_pc;
    logic [`CPU_XLEN-1:0]   id_rs_val, id_rt_val;
    logic                   id_valid, id_issue;
    ctrl_t                  id_ctrl;
    logic [`CPU_REG_AW-1:0] id_rs, id_rt, id_rd, id_dest;
    logic [15:0]            id_imm;
    logic [4:0]             id_shamt;
    logic [25:0]            id_jidx;
    logic                   stall, flush;
    fwd_sel_e               fwd_a, fwd_b;

    // EX
    logic                   ex_valid;
    ctrl_t                  ex_ctrl;
    logic [`CPU_XLEN-1:0]   ex_pc, ex_rs_val, ex_rt_val;
    logic [`CPU_XLEN-1:0]   ex_result, ex_store, ex_target;
    logic                   ex_redirect;
    logic [15:0]            ex_imm;
    logic [4:0]             ex_shamt;
    logic [25:0]            ex_jidx;
    logic [`CPU_REG_AW-1:0] ex_rs, ex_rt, ex_rd;

    // MEM
    logic                   mem_valid;
    ctrl_t                  mem_ctrl;
    logic [`CPU_XLEN-1:0]   mem_pc, mem_result, mem_store;
    logic [`CPU_REG_AW-1:0] mem_rd;

    // WB
    logic                   wb_valid, wb_we;
    ctrl_t                  wb_ctrl;
    logic [`CPU_XLEN-1:0]   wb_pc, wb_alu, wb_result;
    logic [`CPU_REG_AW-1:0] wb_rd;

    fetch_unit fetch_unit_inst (
        .clk        (clk),
        .resetn     (resetn),
        .stall      (stall),
        .redirect   (ex_redirect),
        .target     (ex_target),
        .inst_rdata (inst_sram_rdata),
        .pc         (if_pc),
        .id_instr   (id_instr),
        .id_pc      (id_pc)
    );

    decoder decoder_inst (
        .instr      (id_instr),
        .ctrl       (id_ctrl),
        .rs         (id_rs),
        .rt         (id_rt),
        .rd         (id_rd),
        .imm        (id_imm),
        .shamt      (id_shamt),
        .jump_index (id_jidx)
    );

    assign id_dest = id_ctrl.link    ? `CPU_REG_AW'd31
                   : id_ctrl.dest_rt ? id_rt : id_rd;

    reg_file reg_file_inst (
        .clk     (clk),
        .resetn  (resetn),
        .raddr_a (id_rs),
        .raddr_b (id_rt),
        .we      (wb_we),
        .waddr   (wb_rd),
        .wdata   (wb_result),
        .rdata_a (id_rs_val),
        .rdata_b (id_rt_val)
    );

    hazard_unit hazard_unit_inst (
        .clk           (clk),
        .id_rs         (id_rs),
        .id_rt         (id_rt),
        .ex_rs         (ex_rs),
        .ex_rt         (ex_rt),
        .ex_valid      (ex_valid),
        .ex_mem_read   (ex_ctrl.mem_read),
        .mem_valid     (mem_valid),
        .mem_reg_write (mem_ctrl.reg_write),
        .mem_rd        (mem_rd),
        .wb_valid      (wb_valid),
        .wb_reg_write  (wb_ctrl.reg_write),
        .wb_rd         (wb_rd),
        .redirect      (ex_redirect),
        .ex_rd         (ex_rd),
        .fwd_a         (fwd_a),
        .fwd_b         (fwd_b),
        .stall         (stall),
        .flush         (flush)
    );

    execute_stage execute_stage_inst (
        .ctrl       (ex_ctrl),
        .pc         (ex_pc),
        .rs_val     (ex_rs_val),
        .rt_val     (ex_rt_val),
        .imm        (ex_imm),
        .shamt      (ex_shamt),
        .jump_index (ex_jidx),
        .fwd_a      (fwd_a),
        .fwd_b      (fwd_b),
        .mem_result (mem_result),
        .wb_result  (wb_result),
        .result     (ex_result),
        .store_data (ex_store),
        .redirect   (ex_redirect),
        .target     (ex_target)
    );

    ////////////////////
    // pipeline registers

    assign id_issue = id_valid && !stall && !flush;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            id_valid  <= 1'b0;
            ex_valid  <= 1'b0;
            ex_ctrl   <= '0;
            mem_valid <= 1'b0;
            mem_ctrl  <= '0;
            wb_valid  <= 1'b0;
            wb_ctrl   <= '0;
        end else begin
            if (flush)
                id_valid <= 1'b0;   // word fetched on the wrong path
            else if (!stall)
                id_valid <= 1'b1;
            ex_valid <= id_issue;
            if (id_issue)
                ex_ctrl <= id_ctrl;
            else
                ex_ctrl <= '0;      // bubble
            mem_valid <= ex_valid;
            mem_ctrl  <= ex_ctrl;
            wb_valid  <= mem_valid;
            wb_ctrl   <= mem_ctrl;
        end
    end

    always_ff @(posedge clk) begin
        ex_pc      <= id_pc;
        ex_rs_val  <= id_rs_val;
        ex_rt_val  <= id_rt_val;
        ex_imm     <= id_imm;
        ex_shamt   <= id_shamt;
        ex_jidx    <= id_jidx;
        ex_rs      <= id_rs;
        ex_rt      <= id_rt;
        ex_rd      <= id_dest;
        mem_pc     <= ex_pc;
        mem_result <= ex_result;
        mem_store  <= ex_store;
        mem_rd     <= ex_rd;
        wb_pc      <= mem_pc;
        wb_alu     <= mem_result;
        wb_rd      <= mem_rd;
    end

    ////////////////////
    // memory and debug ports

    assign inst_sram_en    = 1'b1;
    assign inst_sram_wen   = 4'b0000;
    assign inst_sram_addr  = if_pc;
    assign inst_sram_wdata = '0;

    assign data_sram_en    = 1'b1;
    assign data_sram_wen   = (mem_valid && mem_ctrl.mem_write) ? 4'b1111 : 4'b0000;
    assign data_sram_addr  = {{`CPU_PHYS_MASK_BITS{1'b0}},
                              mem_result[`CPU_XLEN-`CPU_PHYS_MASK_BITS-1:0]};
    assign data_sram_wdata = mem_store;

    assign wb_result = wb_ctrl.mem_read ? data_sram_rdata : wb_alu;  // load data lands in WB
    assign wb_we     = wb_valid && wb_ctrl.reg_write;

    assign debug_wb_pc       = wb_pc;
    assign debug_wb_rf_wen   = (wb_we && wb_rd != '0) ? 4'b1111 : 4'b0000;
    assign debug_wb_rf_wnum  = wb_rd;
    assign debug_wb_rf_wdata = wb_result;

endmodule

/* src/reg_file.sv */
`include "cpu_config.svh"

module reg_file (
    input  logic                   clk,
    input  logic                   resetn,
    input  logic [`CPU_REG_AW-1:0] raddr_a,
    input  logic [`CPU_REG_AW-1:0] raddr_b,
    input  logic                   we,
    input  logic [`CPU_REG_AW-1:0] waddr,
    input  logic [`CPU_XLEN-1:0]   wdata,
    output logic [`CPU_XLEN-1:0]   rdata_a,
    output logic [`CPU_XLEN-1:0]   rdata_b
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++)
                regs[i] <= '0;
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 hardwired, write-through for the WB->ID case
    assign rdata_a = (raddr_a == '0) ? '0
                   : (we && waddr == raddr_a) ? wdata : regs[raddr_a];
    assign rdata_b = (raddr_b == '0) ? '0
                   : (we && waddr == raddr_b) ? wdata : regs[raddr_b];

    // write enable comes from the WB valid bit in the top level
    a_no_write_in_reset: assert property (@(posedge clk) !resetn |-> !we)
        else $error("register write while resetn is low");

endmodule

/* verif/tb_mycpu_top.sv */
`include "cpu_config.svh"

module tb_mycpu_top;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int          PROG_LEN        = 200;
    localparam int          NUM_PROGS       = 3;
    localparam int          ROM_WORDS       = 256;
    localparam int          RAM_WORDS       = 64;
    localparam int          WATCHDOG_CYCLES = NUM_PROGS * (PROG_LEN * 4 + 50);
    localparam logic [31:0] DATA_BASE       = 32'ha000_0000;
    localparam logic [4:0]  BASE_REG        = 5'd28;    // holds DATA_BASE, never a random dest

    localparam logic [5:0] ALU_FUNCTS [8]   = '{6'h21, 6'h23, 6'h24, 6'h25,
                                                6'h26, 6'h27, 6'h2a, 6'h2b};
    localparam logic [5:0] SHIFT_FUNCTS [3] = '{6'h00, 6'h02, 6'h03};
    localparam logic [5:0] IMM_OPS [7]      = '{6'h09, 6'h0a, 6'h0b, 6'h0c,
                                                6'h0d, 6'h0e, 6'h0f};

    logic        clk;
    logic        resetn          = 1'b0;
    logic [31:0] inst_sram_rdata = '0;
    logic [31:0] data_sram_rdata = '0;
    logic        inst_sram_en, data_sram_en;
    logic [3:0]  inst_sram_wen, data_sram_wen, debug_wb_rf_wen;
    logic [31:0] inst_sram_addr, inst_sram_wdata, data_sram_addr, data_sram_wdata;
    logic [31:0] debug_wb_pc, debug_wb_rf_wdata;
    logic [4:0]  debug_wb_rf_wnum;

    integer      seed;
    int          mismatches = 0;
    int          failures   = 0;
    logic [31:0] rom [ROM_WORDS];
    logic [31:0] ram [RAM_WORDS];
    logic [31:0] halt_pc;

    // expected retirement order from the ISA model
    logic [31:0] exp_wpc[$];
    logic [4:0]  exp_wnum[$];
    logic [31:0] exp_wdata[$];
    logic [31:0] exp_saddr[$];
    logic [31:0] exp_sdata[$];

    mycpu_top mycpu_top_inst (
        .clk               (clk),
        .resetn            (resetn),
        .inst_sram_en      (inst_sram_en),
        .inst_sram_wen     (inst_sram_wen),
        .inst_sram_addr    (inst_sram_addr),
        .inst_sram_wdata   (inst_sram_wdata),
        .inst_sram_rdata   (inst_sram_rdata),
        .data_sram_en      (data_sram_en),
        .data_sram_wen     (data_sram_wen),
        .data_sram_addr    (data_sram_addr),
        .data_sram_wdata   (data_sram_wdata),
        .data_sram_rdata   (data_sram_rdata),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] ram_fill(input logic [31:0] addr);
        return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
    endfunction

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    ////////////////////
    // memories, one cycle read

    always @(posedge clk) begin
        if (inst_sram_en)
            inst_sram_rdata <= rom[inst_sram_addr[9:2]];
        if (!resetn) begin
            for (int i = 0; i < RAM_WORDS; i++)
                ram[i] <= ram_fill(DATA_BASE + 32'(i) * 4);
        end else if (data_sram_en) begin
            if (data_sram_wen == 4'b1111)
                ram[data_sram_addr[7:2]] <= data_sram_wdata;
            data_sram_rdata <= ram[data_sram_addr[7:2]];
        end
    end

    ////////////////////
    // program generator

    function automatic logic [31:0] random_instr(input int idx);
        int          kind, tgt;
        logic [4:0]  rs, rt, rd;
        logic [15:0] imm;
        logic [31:0] tpc;
        kind = rand_below(100);
        rs   = 5'(rand_below(8));   // small register set keeps hazards frequent
        rt   = 5'(rand_below(8));
        rd   = 5'(rand_below(8));
        imm  = 16'($random(seed));
        tgt  = idx + 1 + rand_below(4);     // forward only
        if (tgt > PROG_LEN + 1)
            tgt = PROG_LEN + 1;
        tpc = `CPU_RESET_PC + 32'(tgt) * 4;
        if (kind < 30)
            return {6'h00, rs, rt, rd, 5'd0, ALU_FUNCTS[rand_below(8)]};
        else if (kind < 42)
            return {6'h00, 5'd0, rt, rd, imm[10:6], SHIFT_FUNCTS[rand_below(3)]};
        else if (kind < 66)
            return {IMM_OPS[rand_below(7)], rs, rt, imm};
        else if (kind < 78)
            return {6'h23, BASE_REG, rt, 16'(rand_below(RAM_WORDS) * 4)};   // lw
        else if (kind < 88)
            return {6'h2b, BASE_REG, rt, 16'(rand_below(RAM_WORDS) * 4)};   // sw
        else if (kind < 95)
            return {(kind < 92) ? 6'h04 : 6'h05, rs, rt, 16'(tgt - idx - 1)};
        else
            return {(kind < 98) ? 6'h02 : 6'h03, tpc[27:2]};                // j / jal
    endfunction

    task automatic gen_program();
        for (int i = 0; i < ROM_WORDS; i++)
            rom[i] = 32'h0000_0000;                            // sll r0 as nop
        rom[0] = {6'h0f, 5'd0, BASE_REG, DATA_BASE[31:16]};   // lui base
        for (int i = 1; i <= PROG_LEN; i++)
            rom[i] = random_instr(i);
        halt_pc = `CPU_RESET_PC + 32'(PROG_LEN + 1) * 4;
        rom[PROG_LEN + 1] = {6'h02, halt_pc[27:2]};           // j to itself
    endtask

    ////////////////////
    // ISA model, no delay slot

    task automatic run_model();
        logic [31:0] regs [32];
        logic [31:0] mem [RAM_WORDS];
        logic [31:0] pc, nxt, instr, a, b, imm_s, imm_z, res, addr;
        logic [4:0]  dest;
        logic        wr;
        int          steps;
        exp_wpc.delete();
        exp_wnum.delete();
        exp_wdata.delete();
        exp_saddr.delete();
        exp_sdata.delete();
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < RAM_WORDS; i++)
            mem[i] = ram_fill(DATA_BASE + 32'(i) * 4);
        pc    = `CPU_RESET_PC;
        steps = 0;
        while (pc != halt_pc && steps < 4 * ROM_WORDS) begin
            instr = rom[pc[9:2]];
            a     = regs[instr[25:21]];
            b     = regs[instr[20:16]];
            imm_s = {{16{instr[15]}}, instr[15:0]};
            imm_z = {16'h0000, instr[15:0]};
            dest  = instr[20:16];
            wr    = 1'b1;
            res   = '0;
            addr  = a + imm_s;
            nxt   = pc + 4;
            case (instr[31:26])
                6'h00: begin
                    dest = instr[15:11];
                    case (instr[5:0])
                        6'h00:   res = b << instr[10:6];
                        6'h02:   res = b >> instr[10:6];
                        6'h03:   res = $unsigned($signed(b) >>> instr[10:6]);
                        6'h21:   res = a + b;
                        6'h23:   res = a - b;
                        6'h24:   res = a & b;
                        6'h25:   res = a | b;
                        6'h26:   res = a ^ b;
                        6'h27:   res = ~(a | b);
                        6'h2a:   res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        6'h2b:   res = (a < b) ? 32'd1 : 32'd0;
                        default: wr = 1'b0;
                    endcase
                end
                6'h02, 6'h03: begin
                    wr   = instr[26];      // jal links
                    dest = 5'd31;
                    res  = pc + 8;
                    nxt  = {pc[31:28], instr[25:0], 2'b00};
                end
                6'h04, 6'h05: begin
                    wr = 1'b0;
                    if ((a == b) != instr[26])
                        nxt = pc + 4 + (imm_s << 2);
                end
                6'h09:   res = a + imm_s;
                6'h0a:   res = ($signed(a) < $signed(imm_s)) ? 32'd1 : 32'd0;
                6'h0b:   res = (a < imm_s) ? 32'd1 : 32'd0;
                6'h0c:   res = a & imm_z;
                6'h0d:   res = a | imm_z;
                6'h0e:   res = a ^ imm_z;
                6'h0f:   res = {instr[15:0], 16'h0000};
                6'h23:   res = mem[addr[7:2]];
                6'h2b: begin
                    wr = 1'b0;
                    mem[addr[7:2]] = b;
                    exp_saddr.push_back(addr);
                    exp_sdata.push_back(b);
                end
                default: wr = 1'b0;
            endcase
            if (wr && dest != 5'd0) begin
                regs[dest] = res;
                exp_wpc.push_back(pc);
                exp_wnum.push_back(dest);
                exp_wdata.push_back(res);
            end
            pc = nxt;
            steps++;
        end
    endtask

    ////////////////////
    // checkers

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    always @(negedge clk) begin
        // instruction port read only, both ports always enabled
        compare_value("inst_sram_en", {31'd0, inst_sram_en}, 32'd1);
        compare_value("inst_sram_wen", {28'd0, inst_sram_wen}, 32'd0);
        compare_value("inst_sram_wdata", inst_sram_wdata, 32'd0);
        compare_value("data_sram_en", {31'd0, data_sram_en}, 32'd1);
        if (!resetn) begin
            if (debug_wb_rf_wen != 4'b0000) begin
                failures++;
                $display("debug register write seen while reset is asserted");
            end
            if (data_sram_wen != 4'b0000) begin
                failures++;
                $display("data store seen while reset is asserted");
            end
        end else begin
            if (debug_wb_rf_wen != 4'b0000) begin
                compare_value("debug_wb_rf_wen", {28'd0, debug_wb_rf_wen}, 32'h0000_000f);
                if (exp_wpc.size() == 0) begin
                    failures++;
                    $display("register write to r%0d at pc %h that the model never made",
                             debug_wb_rf_wnum, debug_wb_pc);
                end else begin
                    compare_value("debug_wb_pc", debug_wb_pc, exp_wpc.pop_front());
                    compare_value("debug_wb_rf_wnum", {27'd0, debug_wb_rf_wnum},
                                  {27'd0, exp_wnum.pop_front()});
                    compare_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_wdata.pop_front());
                end
            end
            if (data_sram_wen != 4'b0000) begin
                compare_value("data_sram_wen", {28'd0, data_sram_wen}, 32'h0000_000f);
                if (exp_saddr.size() == 0) begin
                    failures++;
                    $display("store to %h that the model never made", data_sram_addr);
                end else begin
                    compare_value("data_sram_addr", data_sram_addr,
                                  exp_saddr.pop_front() & 32'h1fff_ffff);  // kseg1 to physical
                    compare_value("data_sram_wdata", data_sram_wdata, exp_sdata.pop_front());
                end
            end
        end
    end

    // halt loop entered repeatedly means everything older has retired
    task automatic wait_for_halt();
        int          entries;
        logic [31:0] prev;
        entries = 0;
        prev    = '0;
        while (entries < 4) begin
            @(negedge clk);
            if (inst_sram_addr == halt_pc && prev != halt_pc)
                entries++;
            prev = inst_sram_addr;
        end
    endtask

    initial begin
        seed = 32'h113e_9d1c;
        for (int p = 0; p < NUM_PROGS; p++) begin
            @(posedge clk);
            resetn <= 1'b0;
            gen_program();          // rom only changes while the core is held in reset
            run_model();
            repeat (5) @(posedge clk);
            resetn <= 1'b1;
            @(negedge clk);
            compare_value("inst_sram_addr", inst_sram_addr, `CPU_RESET_PC);
            wait_for_halt();
            if (exp_wpc.size() != 0) begin
                failures++;
                $display("program %0d halted with %0d register writes never seen",
                         p, exp_wpc.size());
            end
            if (exp_saddr.size() != 0) begin
                failures++;
                $display("program %0d halted with %0d stores never seen", p, exp_saddr.size());
            end
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches + failures == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles before the last program halted",
                 WATCHDOG_CYCLES);
        $display("tests failed");
        $finish;
    end

endmodule
